// File: hw/isa_pkg.sv
// instruction set of the 8-bit core; opcodes 8 to 15 are undefined and trap to the fault routine
`default_nettype none

package isa_pkg;

    // instruction word and datapath sizes
    localparam int word_width    = 16;
    localparam int reg_sel_width = 2;
    localparam int data_width    = 8;
    localparam int pc_width      = 8;
    localparam int opcode_width  = 4;

    // field positions inside the instruction word
    localparam int opcode_lsb = 12;
    localparam int rd_lsb     = 10;
    localparam int rs_lsb     = 8;
    localparam int imm_lsb    = 0;

    // codes at or above this value are undefined
    localparam int num_opcodes = 8;

    typedef enum logic [opcode_width-1:0] {
        op_nop  = 4'd0,
        op_ldi  = 4'd1,
        op_add  = 4'd2,
        op_sub  = 4'd3,
        op_xor  = 4'd4,
        op_out  = 4'd5,
        // rd is decremented, branch to imm while non-zero
        op_djnz = 4'd6,
        op_hlt  = 4'd7
    } opcode_t;

    localparam logic [data_width-1:0] bad_opcode_value = 8'hEE;

endpackage

`default_nettype wire

// File: hw/ucode_pkg.sv
// microinstruction format and fixed ROM addresses; opcodes dispatch to the address equal to their code
`default_nettype none

package ucode_pkg;

    localparam int rom_entries      = 32;
    localparam int ucode_addr_width = $clog2(rom_entries);

    // instruction queue in the prefetch stage
    localparam int queue_depth       = 4;
    localparam int queue_ptr_width   = $clog2(queue_depth);
    localparam int queue_count_width = queue_ptr_width + 1;

    typedef logic [ucode_addr_width-1:0] ucode_addr_t;

    typedef enum logic [1:0] {
        jump_uncond   = 2'd0,
        jump_dispatch = 2'd1,
        jump_zero     = 2'd2,
        jump_stay     = 2'd3
    } jump_t;

    typedef enum logic [2:0] {
        alu_none     = 3'd0,
        alu_pass_imm = 3'd1,
        alu_add      = 3'd2,
        alu_sub      = 3'd3,
        alu_xor      = 3'd4,
        alu_dec      = 3'd5,
        alu_fault    = 3'd6
    } alu_op_t;

    typedef struct packed {
        ucode_addr_t next;
        jump_t       jump;
        alu_op_t     alu;
        logic        rd_wr;
        logic        out_wr;
        logic        load_ip;
        logic        next_instruction;
    } uinstr_t;

    // entries above the opcode range
    localparam ucode_addr_t fetch_wait_address = 5'd16;
    localparam ucode_addr_t djnz_step_address  = 5'd17;
    localparam ucode_addr_t redirect_address   = 5'd18;
    localparam ucode_addr_t bad_opcode_address = 5'd19;
    localparam ucode_addr_t halt_address       = 5'd20;
    localparam ucode_addr_t reset_address      = 5'd21;

endpackage

`default_nettype wire

// File: hw/prefetch.sv
// Wishbone classic read-only fetch master, one read in flight; a redirect waits for the open ack
`timescale 1ns/1ps
`default_nettype none

module prefetch
    import isa_pkg::*, ucode_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    output logic                  wb_cyc,
    output logic                  wb_stb,
    output logic [pc_width-1:0]   wb_adr,
    input  logic [word_width-1:0] wb_dat_i,
    input  logic                  wb_ack,
    output logic [word_width-1:0] q_word,
    output logic                  q_valid,
    input  logic                  q_take,
    input  logic                  redirect,
    input  logic [pc_width-1:0]   redirect_pc
);

    logic [word_width-1:0]        queue [queue_depth];
    logic [queue_ptr_width-1:0]   rd_ptr;
    logic [queue_ptr_width-1:0]   wr_ptr;
    logic [queue_count_width-1:0] count;
    logic [queue_count_width-1:0] count_next;
    logic [pc_width-1:0]          fetch_pc;
    logic [pc_width-1:0]          start_pc;
    logic                         drop;
    logic                         push;
    logic                         busy_next;
    logic                         start;

    assign wb_stb  = wb_cyc;
    assign q_valid = count != '0;
    assign q_word  = queue[rd_ptr];

    always_comb begin
        // data of a read issued before a redirect is thrown away
        push       = wb_cyc && wb_ack && !drop && !redirect;
        count_next = redirect ? '0 :
                     count + queue_count_width'(push) - queue_count_width'(q_take);
        // a classic cycle stays open until its ack
        busy_next  = wb_cyc && !wb_ack;
        start      = !busy_next && (count_next < queue_count_width'(queue_depth));
        start_pc   = redirect ? redirect_pc : fetch_pc;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_cyc   <= 1'b0;
            wb_adr   <= '0;
            fetch_pc <= '0;
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            count    <= '0;
            drop     <= 1'b0;
        end else begin
            count <= count_next;
            if (redirect) begin
                rd_ptr <= '0;
                wr_ptr <= '0;
            end else begin
                if (push)
                    wr_ptr <= wr_ptr + 1'b1;
                if (q_take)
                    rd_ptr <= rd_ptr + 1'b1;
            end

            if (redirect)
                drop <= busy_next;
            else if (wb_ack)
                drop <= 1'b0;

            if (start) begin
                wb_cyc   <= 1'b1;
                wb_adr   <= start_pc;
                fetch_pc <= start_pc + 1'b1;
            end else begin
                if (!busy_next)
                    wb_cyc <= 1'b0;
                // remember the target until the stale cycle completes
                if (redirect)
                    fetch_pc <= redirect_pc;
            end
        end
    end

    // queue storage
    always_ff @(posedge clk) begin
        if (push)
            queue[wr_ptr] <= wb_dat_i;
    end

endmodule

`default_nettype wire

// File: hw/decoder.sv
// single instruction register; codes outside opcode_t are flagged invalid, not decoded
`timescale 1ns/1ps
`default_nettype none

module decoder
    import isa_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic [word_width-1:0]    q_word,
    input  logic                     q_valid,
    output logic                     q_take,
    input  logic                     consume,
    input  logic                     redirect,
    output logic                     ir_valid,
    output opcode_t                  ir_opcode,
    output logic [reg_sel_width-1:0] ir_rd,
    output logic [reg_sel_width-1:0] ir_rs,
    output logic [data_width-1:0]    ir_imm,
    output logic                     ir_invalid
);

    logic [word_width-1:0]   ir_word;
    logic [opcode_width-1:0] code;

    // load when empty or when the sequencer frees the register this cycle
    assign q_take = q_valid && (!ir_valid || consume) && !redirect;

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            ir_valid <= 1'b0;
        else if (redirect)
            ir_valid <= 1'b0;
        else if (q_take)
            ir_valid <= 1'b1;
        else if (consume)
            ir_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (q_take)
            ir_word <= q_word;
    end

    assign code       = ir_word[opcode_lsb +: opcode_width];
    assign ir_opcode  = opcode_t'(code);
    assign ir_invalid = code >= opcode_width'(num_opcodes);
    assign ir_rd      = ir_word[rd_lsb +: reg_sel_width];
    assign ir_rs      = ir_word[rs_lsb +: reg_sel_width];
    assign ir_imm     = ir_word[imm_lsb +: data_width];

endmodule

`default_nettype wire

// File: hw/microcode.sv
// microcode sequencer with a 32-entry constant ROM; only stall is waiting at fetch_wait_address
`timescale 1ns/1ps
`default_nettype none

module microcode
    import isa_pkg::*, ucode_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     ir_valid,
    input  opcode_t                  ir_opcode,
    input  logic                     ir_invalid,
    input  logic [reg_sel_width-1:0] ir_rd,
    input  logic [reg_sel_width-1:0] ir_rs,
    input  logic [data_width-1:0]    ir_imm,
    output logic                     consume,
    input  logic                     zf,
    output alu_op_t                  alu_op,
    output logic                     rd_wr,
    output logic                     out_wr,
    output logic [reg_sel_width-1:0] op_rd,
    output logic [reg_sel_width-1:0] op_rs,
    output logic [data_width-1:0]    op_imm,
    output logic                     redirect,
    output logic [pc_width-1:0]      redirect_pc,
    output logic                     halted
);

    ucode_addr_t addr;
    ucode_addr_t next_addr;
    uinstr_t     current;
    logic        dispatch;

    function automatic uinstr_t entry(input ucode_addr_t next, input jump_t jump,
                                      input alu_op_t alu, input logic w_rd,
                                      input logic w_out, input logic ld_ip,
                                      input logic ni);
        uinstr_t u;
        u.next             = next;
        u.jump             = jump;
        u.alu              = alu;
        u.rd_wr            = w_rd;
        u.out_wr           = w_out;
        u.load_ip          = ld_ip;
        u.next_instruction = ni;
        return u;
    endfunction

    function automatic uinstr_t rom_lookup(input ucode_addr_t a);
        uinstr_t u;
        case (a)
            ucode_addr_t'(op_nop):
                u = entry(fetch_wait_address, jump_uncond, alu_none, 0, 0, 0, 1);
            ucode_addr_t'(op_ldi):
                u = entry(fetch_wait_address, jump_uncond, alu_pass_imm, 1, 0, 0, 1);
            ucode_addr_t'(op_add):
                u = entry(fetch_wait_address, jump_uncond, alu_add, 1, 0, 0, 1);
            ucode_addr_t'(op_sub):
                u = entry(fetch_wait_address, jump_uncond, alu_sub, 1, 0, 0, 1);
            ucode_addr_t'(op_xor):
                u = entry(fetch_wait_address, jump_uncond, alu_xor, 1, 0, 0, 1);
            ucode_addr_t'(op_out):
                u = entry(fetch_wait_address, jump_uncond, alu_none, 0, 1, 0, 1);
            // decrement, then test the flag in the following step
            ucode_addr_t'(op_djnz):
                u = entry(djnz_step_address, jump_uncond, alu_dec, 1, 0, 0, 0);
            ucode_addr_t'(op_hlt):
                u = entry(halt_address, jump_uncond, alu_none, 0, 0, 0, 0);
            fetch_wait_address:
                u = entry(fetch_wait_address, jump_dispatch, alu_none, 0, 0, 0, 0);
            // zero falls out of the loop, non-zero steps to the redirect entry
            djnz_step_address:
                u = entry(fetch_wait_address, jump_zero, alu_none, 0, 0, 0, 0);
            redirect_address:
                u = entry(fetch_wait_address, jump_uncond, alu_none, 0, 0, 1, 0);
            bad_opcode_address:
                u = entry(halt_address, jump_uncond, alu_fault, 0, 1, 0, 0);
            halt_address:
                u = entry(halt_address, jump_stay, alu_none, 0, 0, 0, 0);
            reset_address:
                u = entry(fetch_wait_address, jump_uncond, alu_none, 0, 0, 0, 0);
            // undefined opcodes and unused slots
            default:
                u = entry(bad_opcode_address, jump_uncond, alu_none, 0, 0, 0, 0);
        endcase
        return u;
    endfunction

    assign current  = rom_lookup(addr);
    assign dispatch = current.jump == jump_dispatch || current.next_instruction;
    assign consume  = dispatch && ir_valid;

    always_comb begin
        if (dispatch) begin
            if (!ir_valid)
                next_addr = fetch_wait_address;
            else if (ir_invalid)
                next_addr = bad_opcode_address;
            else
                next_addr = ucode_addr_t'(ir_opcode);
        end else begin
            case (current.jump)
                jump_zero: next_addr = zf ? current.next : addr + 1'b1;
                jump_stay: next_addr = addr;
                default:   next_addr = current.next;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            addr   <= reset_address;
            halted <= 1'b0;
        end else begin
            addr   <= next_addr;
            halted <= addr == halt_address;
        end
    end

    // fields of the instruction being executed
    always_ff @(posedge clk) begin
        if (consume) begin
            op_rd  <= ir_rd;
            op_rs  <= ir_rs;
            op_imm <= ir_imm;
        end
    end

    assign alu_op      = current.alu;
    assign rd_wr       = current.rd_wr;
    assign out_wr      = current.out_wr;
    assign redirect    = current.load_ip;
    // djnz target comes from the immediate
    assign redirect_pc = op_imm;

endmodule

`default_nettype wire

// File: hw/datapath.sv
// four 8-bit registers and a combinational ALU; zf changes only on add, sub, xor and dec
`timescale 1ns/1ps
`default_nettype none

module datapath
    import isa_pkg::*, ucode_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  alu_op_t                  alu_op,
    input  logic                     rd_wr,
    input  logic                     out_wr,
    input  logic [reg_sel_width-1:0] op_rd,
    input  logic [reg_sel_width-1:0] op_rs,
    input  logic [data_width-1:0]    op_imm,
    output logic                     zf,
    output logic                     out_valid,
    output logic [data_width-1:0]    out_data
);

    logic [data_width-1:0] regs [2**reg_sel_width];
    logic [data_width-1:0] a;
    logic [data_width-1:0] b;
    logic [data_width-1:0] result;
    logic                  flag_wr;

    assign a = regs[op_rd];
    assign b = regs[op_rs];

    always_comb begin
        flag_wr = 1'b1;
        case (alu_op)
            alu_pass_imm: result = op_imm;
            alu_add:      result = a + b;
            alu_sub:      result = a - b;
            alu_xor:      result = a ^ b;
            alu_dec:      result = a - 1'b1;
            default:      result = a;
        endcase
        if (alu_op == alu_none || alu_op == alu_pass_imm || alu_op == alu_fault)
            flag_wr = 1'b0;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 2**reg_sel_width; i++)
                regs[i] <= '0;
            zf        <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (rd_wr)
                regs[op_rd] <= result;
            if (flag_wr)
                zf <= result == '0;
            // one-cycle strobe per out or fault
            out_valid <= out_wr;
        end
    end

    always_ff @(posedge clk) begin
        if (out_wr)
            out_data <= (alu_op == alu_fault) ? bad_opcode_value : a;
    end

endmodule

`default_nettype wire

// File: hw/cpu_top.sv
// core top level; the bus is read-only, so no write enable or write data leaves the core
`timescale 1ns/1ps
`default_nettype none

module cpu_top
    import isa_pkg::*, ucode_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    output logic                  wb_cyc,
    output logic                  wb_stb,
    output logic [pc_width-1:0]   wb_adr,
    input  logic [word_width-1:0] wb_dat_i,
    input  logic                  wb_ack,
    output logic                  out_valid,
    output logic [data_width-1:0] out_data,
    output logic                  halted
);

    logic [word_width-1:0]    q_word;
    logic                     q_valid;
    logic                     q_take;
    logic                     redirect;
    logic [pc_width-1:0]      redirect_pc;
    logic                     consume;
    logic                     ir_valid;
    opcode_t                  ir_opcode;
    logic [reg_sel_width-1:0] ir_rd;
    logic [reg_sel_width-1:0] ir_rs;
    logic [data_width-1:0]    ir_imm;
    logic                     ir_invalid;
    alu_op_t                  alu_op;
    logic                     rd_wr;
    logic                     out_wr;
    logic [reg_sel_width-1:0] op_rd;
    logic [reg_sel_width-1:0] op_rs;
    logic [data_width-1:0]    op_imm;
    logic                     zf;

    prefetch u_prefetch (
        .clk(clk), .reset(reset),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr),
        .wb_dat_i(wb_dat_i), .wb_ack(wb_ack),
        .q_word(q_word), .q_valid(q_valid), .q_take(q_take),
        .redirect(redirect), .redirect_pc(redirect_pc)
    );

    decoder u_decoder (
        .clk(clk), .reset(reset),
        .q_word(q_word), .q_valid(q_valid), .q_take(q_take),
        .consume(consume), .redirect(redirect),
        .ir_valid(ir_valid), .ir_opcode(ir_opcode), .ir_rd(ir_rd), .ir_rs(ir_rs),
        .ir_imm(ir_imm), .ir_invalid(ir_invalid)
    );

    microcode u_microcode (
        .clk(clk), .reset(reset),
        .ir_valid(ir_valid), .ir_opcode(ir_opcode), .ir_invalid(ir_invalid),
        .ir_rd(ir_rd), .ir_rs(ir_rs), .ir_imm(ir_imm), .consume(consume),
        .zf(zf), .alu_op(alu_op), .rd_wr(rd_wr), .out_wr(out_wr),
        .op_rd(op_rd), .op_rs(op_rs), .op_imm(op_imm),
        .redirect(redirect), .redirect_pc(redirect_pc), .halted(halted)
    );

    datapath u_datapath (
        .clk(clk), .reset(reset),
        .alu_op(alu_op), .rd_wr(rd_wr), .out_wr(out_wr),
        .op_rd(op_rd), .op_rs(op_rs), .op_imm(op_imm),
        .zf(zf), .out_valid(out_valid), .out_data(out_data)
    );

endmodule

`default_nettype wire

// File: sim/cpu_sva.sv
// protocol assertions bound into cpu_top; all checks are off while reset is high
`timescale 1ns/1ps
`default_nettype none

module cpu_sva
    import isa_pkg::*;
(
    input logic                clk,
    input logic                reset,
    input logic                wb_cyc,
    input logic                wb_stb,
    input logic [pc_width-1:0] wb_adr,
    input logic                wb_ack,
    input logic                out_valid,
    input logic                halted
);

    stb_needs_cyc: assert property (@(posedge clk) disable iff (reset) wb_stb |-> wb_cyc)
        else $error("wb_stb asserted without wb_cyc");

    // a classic request holds its address until ack
    adr_held: assert property (@(posedge clk) disable iff (reset)
        wb_cyc && wb_stb && !wb_ack |=> wb_cyc && $stable(wb_adr))
        else $error("wb_adr changed or cycle dropped before ack");

    quiet_when_halted: assert property (@(posedge clk) disable iff (reset)
        halted |-> !out_valid)
        else $error("out_valid seen while halted");

    halt_sticky: assert property (@(posedge clk) disable iff (reset) halted |=> halted)
        else $error("halted fell without reset");

endmodule

bind cpu_top cpu_sva u_sva (
    .clk(clk),
    .reset(reset),
    .wb_cyc(wb_cyc),
    .wb_stb(wb_stb),
    .wb_adr(wb_adr),
    .wb_ack(wb_ack),
    .out_valid(out_valid),
    .halted(halted)
);

`default_nettype wire

// File: sim/cpu_tb.sv
// testbench for cpu_top; memory past each program holds undefined opcodes, djnz targets must be in range
`timescale 1ns/1ps
`default_nettype none

module cpu_tb
    import isa_pkg::*;
();

    localparam int num_tests      = 7;
    localparam int cycles_per_word = 40;
    localparam int drain_cycles    = 8;

    logic                  clk = 1'b0;
    logic                  reset = 1'b1;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic [pc_width-1:0]   wb_adr;
    logic [word_width-1:0] wb_dat_i = '0;
    logic                  wb_ack = 1'b0;
    logic                  out_valid;
    logic [data_width-1:0] out_data;
    logic                  halted;

    logic [word_width-1:0] mem [256];
    logic [word_width-1:0] prog [$];
    logic [data_width-1:0] exp_bytes [$];
    bit                    exp_halt;

    int seed = 32'h2049;
    int max_delay = 3;
    int delay_left = 0;
    bit req_open = 1'b0;
    int got_count = 0;
    int error_count = 0;
    int test_count = 0;
    int limit_cycles = 0;

    string test_name [num_tests] = '{"alu_wrap", "djnz_loop", "random_ack", "queue_full",
                                     "bad_opcode", "halt_stop", "reset_mid"};
    int    test_prog [num_tests] = '{0, 1, 2, 2, 3, 4, 2};
    int    test_delay [num_tests] = '{3, 3, 3, 0, 3, 3, 3};
    // outputs seen before the reset is pulsed, 0 for no reset
    int    test_reset_after [num_tests] = '{0, 0, 0, 0, 0, 0, 2};

    cpu_top u_dut (
        .clk(clk), .reset(reset),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr),
        .wb_dat_i(wb_dat_i), .wb_ack(wb_ack),
        .out_valid(out_valid), .out_data(out_data), .halted(halted)
    );

    always #4 clk = ~clk;

    function automatic logic [word_width-1:0] encode(input logic [3:0] op, input int rd,
                                                     input int rs, input int imm);
        return {op, rd[1:0], rs[1:0], imm[7:0]};
    endfunction

    function automatic void build_program(input int id);
        prog.delete();
        case (id)
            0: begin
                prog.push_back(encode(op_ldi, 0, 0, 8'h7F));
                prog.push_back(encode(op_ldi, 1, 0, 8'h95));
                prog.push_back(encode(op_add, 0, 1, 0));
                prog.push_back(encode(op_out, 0, 0, 0));
                prog.push_back(encode(op_ldi, 2, 0, 8'h10));
                prog.push_back(encode(op_sub, 2, 1, 0));
                prog.push_back(encode(op_out, 2, 0, 0));
                prog.push_back(encode(op_xor, 1, 0, 0));
                prog.push_back(encode(op_out, 1, 0, 0));
                prog.push_back(encode(op_nop, 0, 0, 0));
                prog.push_back(encode(op_ldi, 3, 0, 8'h33));
                prog.push_back(encode(op_sub, 3, 3, 0));
                prog.push_back(encode(op_out, 3, 0, 0));
                prog.push_back(encode(op_hlt, 0, 0, 0));
            end
            1: begin
                prog.push_back(encode(op_ldi, 0, 0, 4));
                prog.push_back(encode(op_ldi, 1, 0, 8'h1C));
                prog.push_back(encode(op_out, 0, 0, 0));
                prog.push_back(encode(op_djnz, 0, 0, 2));
                prog.push_back(encode(op_out, 1, 0, 0));
                prog.push_back(encode(op_hlt, 0, 0, 0));
                // only reached if the flush leaks
                prog.push_back(encode(op_out, 0, 0, 0));
                prog.push_back(encode(op_out, 1, 0, 0));
            end
            2: begin
                prog.push_back(encode(op_ldi, 0, 0, 3));
                prog.push_back(encode(op_ldi, 1, 0, 8'hF0));
                prog.push_back(encode(op_ldi, 2, 0, 8'h25));
                prog.push_back(encode(op_add, 1, 2, 0));
                prog.push_back(encode(op_out, 1, 0, 0));
                prog.push_back(encode(op_xor, 2, 1, 0));
                prog.push_back(encode(op_djnz, 0, 0, 3));
                // a second djnz that falls through fills the queue when acks come at once
                prog.push_back(encode(op_ldi, 3, 0, 1));
                prog.push_back(encode(op_djnz, 3, 0, 0));
                prog.push_back(encode(op_out, 2, 0, 0));
                prog.push_back(encode(op_hlt, 0, 0, 0));
            end
            3: begin
                prog.push_back(encode(op_ldi, 0, 0, 8'h42));
                prog.push_back(encode(op_out, 0, 0, 0));
                prog.push_back(encode(4'hB, 1, 2, 8'h5C));
                prog.push_back(encode(op_out, 0, 0, 0));
                prog.push_back(encode(op_hlt, 0, 0, 0));
            end
            default: begin
                prog.push_back(encode(op_ldi, 3, 0, 8'h5A));
                prog.push_back(encode(op_out, 3, 0, 0));
                prog.push_back(encode(op_hlt, 0, 0, 0));
                prog.push_back(encode(op_out, 3, 0, 0));
                prog.push_back(encode(op_ldi, 3, 0, 8'h01));
                prog.push_back(encode(op_out, 3, 0, 0));
            end
        endcase
    endfunction

    function automatic void load_memory();
        for (int i = 0; i < 256; i++)
            mem[i] = 16'hFF00 | 16'(i);
        foreach (prog[i])
            mem[i] = prog[i];
    endfunction

    // ISA interpreter over the memory image, fills the expected output list
    function automatic void ref_run();
        logic [data_width-1:0] r [4];
        logic [pc_width-1:0]   pc;
        logic [word_width-1:0] w;
        logic [1:0]            rd;
        logic [1:0]            rs;
        logic [data_width-1:0] imm;
        int                    steps;
        bit                    done;
        exp_bytes.delete();
        exp_halt = 1'b0;
        for (int i = 0; i < 4; i++)
            r[i] = '0;
        pc = '0;
        steps = 0;
        done = 1'b0;
        while (!done && steps < 1000) begin
            w = mem[pc];
            rd = w[11:10];
            rs = w[9:8];
            imm = w[7:0];
            pc = pc + 8'd1;
            steps++;
            if (w[15:12] >= 4'd8) begin
                exp_bytes.push_back(bad_opcode_value);
                exp_halt = 1'b1;
                done = 1'b1;
            end else begin
                case (w[15:12])
                    op_ldi:  r[rd] = imm;
                    op_add:  r[rd] = r[rd] + r[rs];
                    op_sub:  r[rd] = r[rd] - r[rs];
                    op_xor:  r[rd] = r[rd] ^ r[rs];
                    op_out:  exp_bytes.push_back(r[rd]);
                    op_djnz: begin
                        r[rd] = r[rd] - 8'd1;
                        if (r[rd] != 8'd0)
                            pc = imm;
                    end
                    op_hlt: begin
                        exp_halt = 1'b1;
                        done = 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    endfunction

    task automatic check_data(input string name, input logic [data_width-1:0] got,
                              input logic [data_width-1:0] expected);
        if (got !== expected) begin
            $display("FAILED %s: got 0x%0h expected 0x%0h", name, got, expected);
            error_count++;
        end
    endtask

    task automatic check_halt(input logic got, input logic expected);
        if (got !== expected) begin
            $display("FAILED halted: got 0x%0h expected 0x%0h", got, expected);
            error_count++;
        end
    endtask

    // program memory answering classic reads after a random number of wait cycles
    always @(negedge clk) begin
        if (reset || !(wb_cyc && wb_stb)) begin
            wb_ack <= 1'b0;
            req_open = 1'b0;
        end else begin
            if (!req_open || wb_ack) begin
                req_open = 1'b1;
                delay_left = $unsigned($random(seed)) % (max_delay + 1);
            end else begin
                delay_left = delay_left - 1;
            end
            wb_ack <= delay_left == 0;
            wb_dat_i <= mem[wb_adr];
        end
    end

    always @(negedge clk) begin
        if (!reset && out_valid) begin
            got_count++;
            if (exp_bytes.size() == 0) begin
                $display("unexpected output 0x%0h after the expected sequence ended", out_data);
                error_count++;
            end else begin
                check_data("out_data", out_data, exp_bytes.pop_front());
            end
        end
    end

    // memory image and expected list are rebuilt while reset is held
    task automatic apply_reset();
        @(negedge clk);
        reset <= 1'b1;
        @(negedge clk);
        load_memory();
        ref_run();
        got_count = 0;
        @(negedge clk);
        reset <= 1'b0;
    endtask

    task automatic run_test(input int idx);
        int errors_before;
        int limit;
        int cycles;
        errors_before = error_count;
        build_program(test_prog[idx]);
        limit = prog.size() * cycles_per_word;
        max_delay = test_delay[idx];
        apply_reset();
        if (test_reset_after[idx] > 0) begin
            cycles = 0;
            while (got_count < test_reset_after[idx] && cycles < limit) begin
                @(posedge clk);
                cycles++;
            end
            apply_reset();
        end
        cycles = 0;
        while (!halted && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            $display("test %s: timed out waiting for halted after %0d cycles",
                     test_name[idx], limit);
            error_count++;
        end
        repeat (drain_cycles) @(negedge clk);
        check_halt(halted, exp_halt);
        @(posedge clk);
        if (exp_bytes.size() != 0) begin
            $display("test %s: %0d expected outputs never appeared",
                     test_name[idx], exp_bytes.size());
            error_count++;
        end
        test_count++;
        if (error_count == errors_before)
            $display("test %s: ok, %0d outputs", test_name[idx], got_count);
        else
            $display("test %s: %0d errors", test_name[idx], error_count - errors_before);
    endtask

    initial begin : watchdog
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", limit_cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        int total_words;
        total_words = 0;
        for (int i = 0; i < num_tests; i++) begin
            build_program(test_prog[i]);
            total_words += prog.size() * ((test_reset_after[i] > 0) ? 2 : 1);
        end
        limit_cycles = total_words * cycles_per_word + num_tests * 20;
        for (int i = 0; i < num_tests; i++)
            run_test(i);
        $display("tests %0d, errors %0d", test_count, error_count);
        if (error_count == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
hw/isa_pkg.sv
hw/ucode_pkg.sv
hw/prefetch.sv
hw/decoder.sv
hw/microcode.sv
hw/datapath.sv
hw/cpu_top.sv
sim/cpu_sva.sv
sim/cpu_tb.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator, pass only if the pass line is printed
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module cpu_tb -o cpu_tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/cpu_tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "SIMULATION PASSED"; then
    exit 0
fi
exit 1
